// ==== common/exu_config.svh ====
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// ************************************************************
// execute stage widths
// ************************************************************

// data path and address width
`define EXU_XLEN        64

// low half used by the word forms
`define EXU_WORD_W      32

// shift amount widths, full and word
`define EXU_SHAMT_W     6
`define EXU_WSHAMT_W    5

// ************************************************************
// register file indexing
// ************************************************************

`define EXU_REG_W       5

// x0 reads as zero, so it is never a forwarding source
`define EXU_ZERO_REG    5'd0

`endif

// ==== common/exu_pkg.sv ====
`include "exu_config.svh"

package exu_pkg;

    // ************************************************************
    // data types
    // ************************************************************

    typedef logic [`EXU_XLEN-1:0]  xdata_t;
    typedef logic [`EXU_REG_W-1:0] reg_idx_t;

    // ************************************************************
    // operation encodings
    // ************************************************************

    // integer alu operation, word form chosen by a separate flag
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // branch condition, same values as the funct3 field
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_t;

endpackage

// ==== alu/alu_core.sv ====
`include "exu_config.svh"

module alu_core (
    input  exu_pkg::alu_op_t alu_op,
    input  logic             word,
    input  exu_pkg::xdata_t  operand1,
    input  exu_pkg::xdata_t  operand2,
    output exu_pkg::xdata_t  result
);
    import exu_pkg::*;

    localparam int HI_W = `EXU_XLEN - `EXU_WORD_W;

    xdata_t                  op_a;
    xdata_t                  op_b;
    xdata_t                  raw;
    logic [`EXU_SHAMT_W-1:0] shamt;

    function automatic xdata_t sext_word(input logic [`EXU_WORD_W-1:0] w);
        return {{HI_W{w[`EXU_WORD_W-1]}}, w};
    endfunction

    // ************************************************************
    // operand preparation for the word forms
    // ************************************************************
    // sign extension keeps both signed and unsigned order, so only
    // the logical right shift needs the upper half cleared
    always_comb begin
        if (word) begin
            if (alu_op == ALU_SRL) begin
                op_a = {{HI_W{1'b0}}, operand1[`EXU_WORD_W-1:0]};
            end else begin
                op_a = sext_word(operand1[`EXU_WORD_W-1:0]);
            end
            op_b  = sext_word(operand2[`EXU_WORD_W-1:0]);
            shamt = {1'b0, operand2[`EXU_WSHAMT_W-1:0]};
        end else begin
            op_a  = operand1;
            op_b  = operand2;
            shamt = operand2[`EXU_SHAMT_W-1:0];
        end
    end

    // ************************************************************
    // operation select
    // ************************************************************
    always_comb begin
        case (alu_op)
            ALU_ADD:  raw = op_a + op_b;
            ALU_SUB:  raw = op_a - op_b;
            ALU_AND:  raw = op_a & op_b;
            ALU_OR:   raw = op_a | op_b;
            ALU_XOR:  raw = op_a ^ op_b;
            ALU_SLL:  raw = op_a << shamt;
            ALU_SRL:  raw = op_a >> shamt;
            ALU_SRA:  raw = $signed(op_a) >>> shamt;
            ALU_SLT:  raw = {{(`EXU_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: raw = {{(`EXU_XLEN-1){1'b0}}, op_a < op_b};
            default:  raw = '0;
        endcase
    end

    // word forms keep the low half, sign extended
    assign result = word ? sext_word(raw[`EXU_WORD_W-1:0]) : raw;

endmodule

// ==== alu/branch_unit.sv ====
`include "exu_config.svh"

module branch_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               id_valid,
    input  logic               id_ready,
    input  logic               id_branch,
    input  logic               id_jump,
    input  exu_pkg::br_cond_t  id_cond,
    input  exu_pkg::xdata_t    operand1,
    input  exu_pkg::xdata_t    operand2,
    input  exu_pkg::xdata_t    operand3,
    input  exu_pkg::xdata_t    id_operand4,
    input  exu_pkg::xdata_t    id_next_pc,
    input  logic               load_use,
    output logic               jump_flag,
    output exu_pkg::xdata_t    jump_addr,
    output exu_pkg::xdata_t    next_pc
);
    import exu_pkg::*;

    logic   taken;
    logic   redirect;
    logic   pulse_q;
    xdata_t target;

    // condition between rs1 and rs2
    always_comb begin
        case (id_cond)
            BR_EQ:   taken = (operand1 == operand2);
            BR_NE:   taken = (operand1 != operand2);
            BR_LT:   taken = ($signed(operand1) < $signed(operand2));
            BR_GE:   taken = ($signed(operand1) >= $signed(operand2));
            BR_LTU:  taken = (operand1 < operand2);
            BR_GEU:  taken = (operand1 >= operand2);
            default: taken = 1'b0;
        endcase
    end

    // pc or rs1 base plus offset
    assign target    = operand3 + id_operand4;
    assign jump_addr = {target[`EXU_XLEN-1:1], 1'b0};

    assign redirect  = id_jump | (id_branch & taken);
    assign next_pc   = redirect ? jump_addr : id_next_pc;

    // ************************************************************
    // one redirect pulse per instruction
    // ************************************************************
    assign jump_flag = id_valid & redirect & ~load_use & ~pulse_q;

    // set once the flag went out, cleared when the instruction leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pulse_q <= 1'b0;
        end else if (id_valid & id_ready) begin
            pulse_q <= 1'b0;
        end else if (jump_flag) begin
            pulse_q <= 1'b1;
        end
    end

endmodule

// ==== logic/operand_forward.sv ====
`include "exu_config.svh"

module operand_forward (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_valid,
    input  logic              id_ready,
    input  exu_pkg::reg_idx_t id_rs1,
    input  exu_pkg::reg_idx_t id_rs2,
    input  logic              id_jalr,
    input  exu_pkg::xdata_t   id_operand1,
    input  exu_pkg::xdata_t   id_operand2,
    input  exu_pkg::xdata_t   id_operand3,
    input  logic              ex_valid,
    input  logic              ex_dest_wen,
    input  logic              ex_load,
    input  exu_pkg::reg_idx_t ex_rd,
    input  exu_pkg::xdata_t   ex_result,
    input  logic              wb_valid,
    input  logic              wb_dest_wen,
    input  exu_pkg::reg_idx_t wb_rd,
    input  exu_pkg::xdata_t   wb_data,
    output exu_pkg::xdata_t   operand1,
    output exu_pkg::xdata_t   operand2,
    output exu_pkg::xdata_t   operand3,
    output logic              load_use
);
    import exu_pkg::*;

    // index 0 is rs1, index 1 is rs2
    reg_idx_t [1:0] rs;
    logic     [1:0] ex_hit;
    logic     [1:0] wb_hit;
    logic     [1:0] fwd_hit;
    xdata_t   [1:0] fwd_data;
    logic     [1:0] held_valid;
    xdata_t   [1:0] held_data;

    assign rs[0] = id_rs1;
    assign rs[1] = id_rs2;

    // ************************************************************
    // source match, youngest producer first
    // ************************************************************
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            ex_hit[i] = ex_valid & ex_dest_wen & (ex_rd == rs[i]) &
                        (rs[i] != `EXU_ZERO_REG);
            wb_hit[i] = wb_valid & wb_dest_wen & (wb_rd == rs[i]) &
                        (rs[i] != `EXU_ZERO_REG);
            fwd_hit[i] = ex_hit[i] | wb_hit[i] | held_valid[i];
            if (ex_hit[i]) begin
                fwd_data[i] = ex_result;
            end else if (wb_hit[i]) begin
                fwd_data[i] = wb_data;
            end else begin
                fwd_data[i] = held_data[i];
            end
        end
    end

    // jalr takes its base from rs1 on operand3
    assign operand1 = (fwd_hit[0] & ~id_jalr) ? fwd_data[0] : id_operand1;
    assign operand3 = (fwd_hit[0] & id_jalr) ? fwd_data[0] : id_operand3;
    assign operand2 = fwd_hit[1] ? fwd_data[1] : id_operand2;

    // load result not ready until writeback
    assign load_use = ex_load & (ex_hit[0] | ex_hit[1]);

    // ************************************************************
    // held writeback values
    // ************************************************************
    // a writeback seen during a stall would otherwise be gone
    // by the time the instruction finally transfers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (id_valid & id_ready) begin
                    held_valid[i] <= 1'b0;
                end else if (id_valid & wb_hit[i]) begin
                    held_valid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (id_valid & wb_hit[i]) begin
                held_data[i] <= wb_data;
            end
        end
    end

endmodule

// ==== logic/ex_ls_reg.sv ====
module ex_ls_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_valid,
    input  logic              load_use,
    input  logic              ls_ready,
    input  exu_pkg::reg_idx_t id_rd,
    input  logic              id_dest_wen,
    input  logic              id_load,
    input  exu_pkg::xdata_t   id_pc,
    input  exu_pkg::xdata_t   next_pc,
    input  exu_pkg::xdata_t   result,
    output logic              id_ready,
    output logic              ex_valid,
    output logic              ex_dest_wen,
    output logic              ex_load,
    output exu_pkg::reg_idx_t ex_rd,
    output exu_pkg::xdata_t   ex_pc,
    output exu_pkg::xdata_t   ex_next_pc,
    output exu_pkg::xdata_t   ex_result
);
    import exu_pkg::*;

    logic     load_en;
    reg_idx_t rd_q;
    logic     dest_wen_q;
    logic     load_q;
    xdata_t   pc_q;
    xdata_t   next_pc_q;
    xdata_t   result_q;

    // ************************************************************
    // handshake
    // ************************************************************
    // register is free when empty or being drained this cycle
    assign load_en  = ~ex_valid | ls_ready;
    assign id_ready = id_valid & load_en & ~load_use;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (load_en) begin
            ex_valid <= id_ready;
        end
    end

    // ************************************************************
    // payload
    // ************************************************************
    always_ff @(posedge clk) begin
        if (id_ready) begin
            rd_q       <= id_rd;
            dest_wen_q <= id_dest_wen;
            load_q     <= id_load;
            pc_q       <= id_pc;
            next_pc_q  <= next_pc;
            result_q   <= result;
        end
    end

    assign ex_rd       = rd_q;
    assign ex_dest_wen = dest_wen_q;
    assign ex_load     = load_q;
    assign ex_pc       = pc_q;
    assign ex_next_pc  = next_pc_q;
    assign ex_result   = result_q;

endmodule

// ==== logic/exu_top.sv ====
module exu_top (
    input  logic              clk,
    input  logic              rst_n,
    // decode side
    input  logic              id_valid,
    output logic              id_ready,
    input  exu_pkg::reg_idx_t id_rs1,
    input  exu_pkg::reg_idx_t id_rs2,
    input  exu_pkg::reg_idx_t id_rd,
    input  logic              id_dest_wen,
    input  logic              id_load,
    input  exu_pkg::xdata_t   id_pc,
    input  exu_pkg::xdata_t   id_next_pc,
    input  exu_pkg::alu_op_t  id_alu_op,
    input  logic              id_word,
    input  logic              id_branch,
    input  exu_pkg::br_cond_t id_cond,
    input  logic              id_jump,
    input  logic              id_jalr,
    input  exu_pkg::xdata_t   id_operand1,
    input  exu_pkg::xdata_t   id_operand2,
    input  exu_pkg::xdata_t   id_operand3,
    input  exu_pkg::xdata_t   id_operand4,
    // load/store side
    input  logic              ls_ready,
    output logic              ex_valid,
    output exu_pkg::reg_idx_t ex_rd,
    output logic              ex_dest_wen,
    output logic              ex_load,
    output exu_pkg::xdata_t   ex_pc,
    output exu_pkg::xdata_t   ex_next_pc,
    output exu_pkg::xdata_t   ex_result,
    // writeback broadcast
    input  logic              wb_valid,
    input  exu_pkg::reg_idx_t wb_rd,
    input  logic              wb_dest_wen,
    input  exu_pkg::xdata_t   wb_data,
    // fetch redirect
    output logic              jump_flag,
    output exu_pkg::xdata_t   jump_addr
);
    import exu_pkg::*;

    xdata_t operand1;
    xdata_t operand2;
    xdata_t operand3;
    xdata_t alu_result;
    xdata_t next_pc;
    logic   load_use;

    // ************************************************************
    // operand decode
    // ************************************************************
    operand_forward u_forward (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_valid    (id_valid),
        .id_ready    (id_ready),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_jalr     (id_jalr),
        .id_operand1 (id_operand1),
        .id_operand2 (id_operand2),
        .id_operand3 (id_operand3),
        .ex_valid    (ex_valid),
        .ex_dest_wen (ex_dest_wen),
        .ex_load     (ex_load),
        .ex_rd       (ex_rd),
        .ex_result   (ex_result),
        .wb_valid    (wb_valid),
        .wb_dest_wen (wb_dest_wen),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .operand1    (operand1),
        .operand2    (operand2),
        .operand3    (operand3),
        .load_use    (load_use)
    );

    // ************************************************************
    // execute
    // ************************************************************
    alu_core u_alu (
        .alu_op   (id_alu_op),
        .word     (id_word),
        .operand1 (operand1),
        .operand2 (operand2),
        .result   (alu_result)
    );

    branch_unit u_branch (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_valid    (id_valid),
        .id_ready    (id_ready),
        .id_branch   (id_branch),
        .id_jump     (id_jump),
        .id_cond     (id_cond),
        .operand1    (operand1),
        .operand2    (operand2),
        .operand3    (operand3),
        .id_operand4 (id_operand4),
        .id_next_pc  (id_next_pc),
        .load_use    (load_use),
        .jump_flag   (jump_flag),
        .jump_addr   (jump_addr),
        .next_pc     (next_pc)
    );

    // ************************************************************
    // result register
    // ************************************************************
    ex_ls_reg u_ex_ls_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_valid    (id_valid),
        .load_use    (load_use),
        .ls_ready    (ls_ready),
        .id_rd       (id_rd),
        .id_dest_wen (id_dest_wen),
        .id_load     (id_load),
        .id_pc       (id_pc),
        .next_pc     (next_pc),
        .result      (alu_result),
        .id_ready    (id_ready),
        .ex_valid    (ex_valid),
        .ex_dest_wen (ex_dest_wen),
        .ex_load     (ex_load),
        .ex_rd       (ex_rd),
        .ex_pc       (ex_pc),
        .ex_next_pc  (ex_next_pc),
        .ex_result   (ex_result)
    );

endmodule

// ==== bench/exu_sva.sv ====
`include "exu_config.svh"

module exu_sva (
    input logic clk,
    input logic rst_n,
    input logic ex_valid,
    input logic ls_ready,
    input logic load_use,
    input logic [`EXU_REG_W+2+3*`EXU_XLEN-1:0] payload
);
    timeunit 1ns;
    timeprecision 1ps;

    // ************************************************************
    // reset
    // ************************************************************
    valid_low_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !ex_valid
    ) else $error("ex_valid high on the first edge after reset");

    // ************************************************************
    // handshake
    // ************************************************************
    // stalled output must not change until load/store takes it
    payload_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ex_valid && !ls_ready) |=> (ex_valid && $stable(payload))
    ) else $error("ex_* payload changed under back-pressure");

    // the consumer of a load stays out of the register
    no_accept_on_load_use: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_use |=> (!ex_valid || $stable(payload))
    ) else $error("instruction accepted during a load-use hazard");

endmodule

bind ex_ls_reg exu_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_valid (ex_valid),
    .ls_ready (ls_ready),
    .load_use (load_use),
    .payload  ({ex_rd, ex_dest_wen, ex_load, ex_pc, ex_next_pc, ex_result})
);

// ==== bench/exu_tb.sv ====
module exu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    localparam int N_ALU    = 200;
    localparam int N_DEP    = 60;
    localparam int N_LOAD   = 40;
    localparam int N_BRANCH = 32;
    localparam int N_PRESS  = 100;
    localparam int TOTAL    = N_ALU + N_DEP + N_LOAD + N_BRANCH + N_PRESS;
    localparam int LIMIT    = 20 * TOTAL + 200;

    typedef struct {
        alu_op_t  op;
        logic     word;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     wen;
        logic     load;
        logic     branch;
        logic     jump;
        logic     jalr;
        br_cond_t cond;
        xdata_t   imm;
        xdata_t   off;
    } instr_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     wen;
        logic     load;
        xdata_t   pc;
        xdata_t   next_pc;
        xdata_t   result;
    } exp_t;

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      id_valid = 1'b0;
    logic      id_ready;
    reg_idx_t  id_rs1 = '0;
    reg_idx_t  id_rs2 = '0;
    reg_idx_t  id_rd = '0;
    logic      id_dest_wen = 1'b0;
    logic      id_load = 1'b0;
    xdata_t    id_pc = '0;
    xdata_t    id_next_pc = '0;
    alu_op_t   id_alu_op = ALU_ADD;
    logic      id_word = 1'b0;
    logic      id_branch = 1'b0;
    br_cond_t  id_cond = BR_EQ;
    logic      id_jump = 1'b0;
    logic      id_jalr = 1'b0;
    xdata_t    id_operand1 = '0;
    xdata_t    id_operand2 = '0;
    xdata_t    id_operand3 = '0;
    xdata_t    id_operand4 = '0;
    logic      ls_ready = 1'b0;
    logic      ex_valid;
    reg_idx_t  ex_rd;
    logic      ex_dest_wen;
    logic      ex_load;
    xdata_t    ex_pc;
    xdata_t    ex_next_pc;
    xdata_t    ex_result;
    logic      wb_valid = 1'b0;
    reg_idx_t  wb_rd = '0;
    logic      wb_dest_wen = 1'b0;
    xdata_t    wb_data = '0;
    logic      jump_flag;
    xdata_t    jump_addr;

    // register values in program order and as written back
    xdata_t      arch [32];
    xdata_t      mirror [32];
    exp_t        exp_q [$];
    logic [31:0] drv_state = 32'he3ec_00ea;
    logic [31:0] rdy_state = 32'he3ec_00ea ^ 32'h0bad_5eed;
    logic        ready_half = 1'b0;
    xdata_t      pc = 64'h8000_0000;
    int          errors = 0;
    int          checks = 0;
    int          issued = 0;
    int          cycles = 0;
    br_cond_t    cond_list [6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};

    exu_top UUT (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    // ************************************************************
    // reference model
    // ************************************************************
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        drv_state = xorshift(drv_state);
        return drv_state;
    endfunction

    function automatic xdata_t ref_alu(alu_op_t op, logic word, xdata_t a, xdata_t b);
        logic [31:0] wa;
        logic [31:0] wb;
        logic [31:0] wr;
        xdata_t      r;
        wa = a[31:0];
        wb = b[31:0];
        if (word) begin
            case (op)
                ALU_ADD:  wr = wa + wb;
                ALU_SUB:  wr = wa - wb;
                ALU_AND:  wr = wa & wb;
                ALU_OR:   wr = wa | wb;
                ALU_XOR:  wr = wa ^ wb;
                ALU_SLL:  wr = wa << b[4:0];
                ALU_SRL:  wr = wa >> b[4:0];
                ALU_SRA:  wr = $signed(wa) >>> b[4:0];
                ALU_SLT:  wr = {31'b0, $signed(wa) < $signed(wb)};
                ALU_SLTU: wr = {31'b0, wa < wb};
                default:  wr = '0;
            endcase
            r = {{32{wr[31]}}, wr};
        end else begin
            case (op)
                ALU_ADD:  r = a + b;
                ALU_SUB:  r = a - b;
                ALU_AND:  r = a & b;
                ALU_OR:   r = a | b;
                ALU_XOR:  r = a ^ b;
                ALU_SLL:  r = a << b[5:0];
                ALU_SRL:  r = a >> b[5:0];
                ALU_SRA:  r = $signed(a) >>> b[5:0];
                ALU_SLT:  r = {63'b0, $signed(a) < $signed(b)};
                ALU_SLTU: r = {63'b0, a < b};
                default:  r = '0;
            endcase
        end
        return r;
    endfunction

    function automatic logic branch_taken(br_cond_t c, xdata_t a, xdata_t b);
        case (c)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return $signed(a) < $signed(b);
            BR_GE:   return $signed(a) >= $signed(b);
            BR_LTU:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // register read as decode sees it with this cycle's writeback
    function automatic xdata_t reg_read(reg_idx_t r);
        if (wb_valid && wb_dest_wen && wb_rd == r && r != 5'd0) begin
            return wb_data;
        end
        return mirror[r];
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ************************************************************
    // stimulus
    // ************************************************************
    function automatic instr_t make_instr();
        instr_t      in;
        logic [31:0] r;
        r = next_random();
        in.op = alu_op_t'(4'(r % 32'd10));
        in.word = r[4];
        in.rs1 = r[9:5];
        in.rs2 = (r[21:20] == 2'd0) ? 5'd0 : r[14:10];
        in.rd = r[19:15];
        in.wen = 1'b1;
        in.load = 1'b0;
        in.branch = 1'b0;
        in.jump = 1'b0;
        in.jalr = 1'b0;
        in.cond = BR_EQ;
        in.imm = {next_random(), next_random()};
        in.off = {{52{r[31]}}, r[31:22], 2'b00};
        return in;
    endfunction

    task automatic issue(input instr_t in);
        xdata_t a;
        xdata_t b;
        xdata_t tgt;
        xdata_t res;
        logic   redir;
        int     flags;
        exp_t   e;
        a = in.jump ? pc : arch[in.rs1];
        b = (in.rs2 == 5'd0) ? in.imm : arch[in.rs2];
        res = ref_alu(in.op, in.word, a, b);
        tgt = ((in.jalr ? arch[in.rs1] : pc) + in.off) & ~64'd1;
        redir = in.jump | (in.branch & branch_taken(in.cond, a, b));
        e = '{in.rd, in.wen, in.load, pc, redir ? tgt : pc + 64'd4, res};
        if (in.wen && in.rd != 5'd0) begin
            arch[in.rd] = in.load ? (res ^ 64'h5a5a) : res;
        end
        id_valid <= 1'b1;
        id_rs1 <= in.rs1;
        id_rs2 <= in.rs2;
        id_rd <= in.rd;
        id_dest_wen <= in.wen;
        id_load <= in.load;
        id_pc <= pc;
        id_next_pc <= pc + 64'd4;
        id_alu_op <= in.op;
        id_word <= in.word;
        id_branch <= in.branch;
        id_cond <= in.cond;
        id_jump <= in.jump;
        id_jalr <= in.jalr;
        id_operand1 <= in.jump ? pc : reg_read(in.rs1);
        id_operand2 <= (in.rs2 == 5'd0) ? in.imm : reg_read(in.rs2);
        id_operand3 <= in.jalr ? reg_read(in.rs1) : pc;
        id_operand4 <= in.off;
        flags = 0;
        forever begin
            @(posedge clk);
            if (jump_flag) begin
                flags++;
                check("jump_addr", jump_addr, tgt);
            end
            if (ex_valid && ex_load && ex_dest_wen && ex_rd != 5'd0 &&
                (ex_rd == in.rs1 || ex_rd == in.rs2)) begin
                check("id_ready during load-use", 64'(id_ready), 64'd0);
            end
            if (id_ready) begin
                break;
            end
        end
        check("jump_flag pulses", 64'(flags), redir ? 64'd1 : 64'd0);
        exp_q.push_back(e);
        issued++;
        pc = pc + 64'd4;
    endtask

    task automatic finish_test(input int n, input string name);
        id_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        $display("test %0d %s finished, errors so far %0d", n, name, errors);
    endtask

    // ************************************************************
    // load/store and writeback model with the compare process
    // ************************************************************
    always @(posedge clk) begin
        exp_t        e;
        logic [31:0] r;
        if (rst_n) begin
            if (wb_valid && wb_dest_wen && wb_rd != 5'd0) begin
                mirror[wb_rd] <= wb_data;
            end
            wb_valid <= ex_valid && ls_ready;
            if (ex_valid && ls_ready) begin
                wb_rd <= ex_rd;
                wb_dest_wen <= ex_dest_wen;
                wb_data <= ex_load ? (ex_result ^ 64'h5a5a) : ex_result;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected result at %0t: nothing was outstanding", $time);
                end else begin
                    e = exp_q.pop_front();
                    check("ex_rd", 64'(ex_rd), 64'(e.rd));
                    check("ex_dest_wen", 64'(ex_dest_wen), 64'(e.wen));
                    check("ex_load", 64'(ex_load), 64'(e.load));
                    check("ex_pc", ex_pc, e.pc);
                    check("ex_next_pc", ex_next_pc, e.next_pc);
                    check("ex_result", ex_result, e.result);
                end
            end
            rdy_state = xorshift(rdy_state);
            r = rdy_state;
            ls_ready <= ready_half ? r[7] : (r[8:7] != 2'b00);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    // ************************************************************
    // test sequence
    // ************************************************************
    initial begin
        instr_t in;
        reg_idx_t last_rd;
        for (int i = 0; i < 32; i++) begin
            arch[i] = (i == 0) ? 64'd0 : {32'(i) * 32'h9e37_79b9, ~32'(i) * 32'h85eb_ca6b};
            mirror[i] = arch[i];
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < N_ALU; i++) begin
            issue(make_instr());
        end
        finish_test(1, "independent alu");

        // dependency chains via the ex/ls register and writeback with some through x0
        last_rd = 5'd1;
        for (int i = 0; i < N_DEP; i++) begin
            in = make_instr();
            if (i % 2 == 0) begin
                in.rs1 = last_rd;
            end else begin
                in.rs2 = last_rd;
            end
            if (i % 7 == 3) begin
                in.rd = 5'd0;
            end
            if (i % 5 != 4) begin
                last_rd = in.rd;
            end
            issue(in);
        end
        finish_test(2, "dependent chains");

        for (int i = 0; i < N_LOAD / 2; i++) begin
            in = make_instr();
            in.op = ALU_ADD;
            in.word = 1'b0;
            in.load = 1'b1;
            in.rd = (in.rd == 5'd0) ? 5'd7 : in.rd;
            last_rd = in.rd;
            issue(in);
            in = make_instr();
            if (i % 2 == 0) begin
                in.rs1 = last_rd;
            end else begin
                in.rs2 = last_rd;
            end
            issue(in);
        end
        finish_test(3, "load-use");

        for (int i = 0; i < 24; i++) begin
            in = make_instr();
            in.op = ALU_ADD;
            in.wen = 1'b0;
            in.branch = 1'b1;
            in.cond = cond_list[i / 4];
            in.rs2 = (in.rs2 == 5'd0) ? 5'd3 : in.rs2;
            in.rs1 = (i % 4 == 0) ? in.rs2 : in.rs1;
            issue(in);
        end
        for (int i = 0; i < 8; i++) begin
            in = make_instr();
            in.op = ALU_ADD;
            in.word = 1'b0;
            in.jump = 1'b1;
            in.jalr = (i >= 4);
            in.rs1 = in.jalr ? in.rs1 : 5'd0;
            in.rs2 = 5'd0;
            in.imm = 64'd4;
            issue(in);
        end
        finish_test(4, "branches and jumps");

        ready_half = 1'b1;
        for (int i = 0; i < N_PRESS; i++) begin
            issue(make_instr());
        end
        finish_test(5, "back-pressure");

        repeat (4) @(posedge clk);
        $display("Summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/exu_pkg.sv
alu/alu_core.sv
alu/branch_unit.sv
logic/operand_forward.sv
logic/ex_ls_reg.sv
logic/exu_top.sv
bench/exu_sva.sv
bench/exu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert --top-module exu_tb -f tb.f -o exu_sim \
    > build.log 2>&1 \
    && ./obj_dir/exu_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -qx "Testbench passed" sim.log && exit 0 || exit 1
